// ==== src/cshPkg.sv ====
package cshPkg;

  // Cache geometry
  localparam int numWays = 4;
  localparam int lruWidth = 2;

  // Diagnostic readout
  localparam int diagSelWidth = 3;
  localparam int diagWidth = 8;

  // Cycle type word, loaded whole from the grants or read by field
  typedef union packed {
    logic [1:0] vec;
    struct packed {
      logic eboxCyc;
      logic chanCyc;
    } fields;
  } cycleWordT;

endpackage

// ==== src/cycleArbiter.sv ====
`timescale 1ns/1ps

module cycleArbiter (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         chanReq,
  input  logic                         eboxReq,
  input  logic                         eboxDone,
  input  logic                         chanDone,
  output logic                         chanGrant,
  output logic                         eboxGrant,
  output logic                         readyToGo,
  output logic [cshPkg::diagWidth-1:0] arbStatus
);
  import cshPkg::*;

  logic idle;
  logic anyGrant;
  logic cycDone;
  cycleWordT cycleWord;
  logic [diagWidth-4:0] grantHist;

  assign readyToGo = idle;

  // Channel wins over EBOX
  assign chanGrant = idle & chanReq;
  assign eboxGrant = idle & eboxReq & ~chanReq;
  assign anyGrant = chanGrant | eboxGrant;

  // Only the done of the running cycle type ends it
  assign cycDone = (cycleWord.fields.eboxCyc & eboxDone) |
                   (cycleWord.fields.chanCyc & chanDone);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idle <= 1'b1;
      cycleWord <= '0;
      grantHist <= '0;
    end else if (anyGrant) begin
      idle <= 1'b0;
      cycleWord.vec <= {eboxGrant, chanGrant};
      // One bit per grant, set for channel
      grantHist <= {grantHist[diagWidth-5:0], chanGrant};
    end else if (cycDone) begin
      idle <= 1'b1;
      cycleWord <= '0;
    end
  end

  assign arbStatus = {grantHist, idle, cycleWord.vec};

endmodule

// ==== src/wayMatchSummary.sv ====
`timescale 1ns/1ps

module wayMatchSummary (
  input  logic [cshPkg::numWays-1:0]   validMatch,
  input  logic [cshPkg::numWays-1:0]   anyWr,
  input  logic [cshPkg::numWays-1:0]   wdVal,
  input  logic [cshPkg::lruWidth-1:0]  lru,
  output logic                         anyValidMatch,
  output logic                         rdFound,
  output logic                         anyWrittenMatch,
  output logic                         lruAnyWr,
  output logic [cshPkg::diagWidth-1:0] wayStatus
);

  // Some way holds the line
  assign anyValidMatch = |validMatch;

  // Matching way also has the word
  assign rdFound = |(validMatch & wdVal);

  // Matching way is dirty
  assign anyWrittenMatch = |(validMatch & anyWr);

  // Victim way is dirty
  assign lruAnyWr = anyWr[lru];

  assign wayStatus = {anyWr, validMatch};

endmodule

// ==== src/eboxSequencer.sv ====
`timescale 1ns/1ps

module eboxSequencer (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         eboxGrant,
  input  logic                         eboxCycAbort,
  input  logic                         vmaRead,
  input  logic                         cacheBit,
  input  logic                         coreDataValid,
  input  logic                         anyValidMatch,
  input  logic                         rdFound,
  input  logic                         lruAnyWr,
  output logic                         eboxDone,
  output logic                         mboxResp,
  output logic                         coreRdRq,
  output logic                         cacheWr,
  output logic                         oneWordWr,
  output logic                         writeback,
  output logic                         eboxRetryReq,
  output logic [cshPkg::diagWidth-1:0] eboxStatus
);

  logic t0;
  logic t1;
  logic t2;
  logic abortDone;
  logic doneQ;
  logic readHit;
  logic readMiss;
  logic writeHit;
  logic writeMiss;
  logic victimDirty;
  logic wbStart;
  logic coreRdStart;
  logic coreRdDone;

  // Timing chain, abort in T1 stops it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      t0 <= 1'b0;
      t1 <= 1'b0;
      t2 <= 1'b0;
    end else begin
      t0 <= eboxGrant;
      t1 <= t0;
      t2 <= t1 & ~eboxCycAbort;
    end
  end

  assign abortDone = t1 & eboxCycAbort;

  // Outcome decode at T2
  assign victimDirty = cacheBit & lruAnyWr;
  assign readHit = vmaRead & rdFound;
  assign readMiss = vmaRead & ~rdFound;
  assign writeHit = ~vmaRead & anyValidMatch;
  assign writeMiss = ~vmaRead & ~anyValidMatch;
  assign wbStart = (readMiss | writeMiss) & victimDirty;
  assign coreRdStart = t2 & readMiss & ~victimDirty;

  // Core read ends on the first data valid seen
  assign coreRdDone = coreRdRq & coreDataValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      doneQ <= 1'b0;
      mboxResp <= 1'b0;
      coreRdRq <= 1'b0;
      cacheWr <= 1'b0;
      oneWordWr <= 1'b0;
      writeback <= 1'b0;
    end else begin
      doneQ <= (t2 & ~coreRdStart) | coreRdDone;
      mboxResp <= (t2 & (readHit | writeHit | (writeMiss & ~victimDirty))) | coreRdDone;
      coreRdRq <= coreRdStart | (coreRdRq & ~coreDataValid);
      // Clean victim on a cached write miss takes the write
      cacheWr <= t2 & (writeHit | (writeMiss & cacheBit & ~lruAnyWr));
      oneWordWr <= t2 & writeMiss & ~cacheBit;
      writeback <= t2 & wbStart;
    end
  end

  assign eboxDone = doneQ | abortDone;

  // Retry goes out with the writeback
  assign eboxRetryReq = writeback;

  assign eboxStatus = {3'b000, writeback, coreRdRq, t2, t1, t0};

endmodule

// ==== src/chanSequencer.sv ====
`timescale 1ns/1ps

module chanSequencer (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         chanGrant,
  input  logic                         chanToMem,
  input  logic                         cacheToMbDone,
  input  logic                         anyValidMatch,
  input  logic                         anyWrittenMatch,
  output logic                         chanDone,
  output logic                         chanWrCache,
  output logic                         chanRdWait,
  output logic [cshPkg::diagWidth-1:0] chanStatus
);

  logic t1;
  logic t2;
  logic t3;
  logic rdWaitStart;
  logic wrHit;

  // Read of a dirty line must wait for the MB transfer
  assign rdWaitStart = t3 & ~chanToMem & anyWrittenMatch;
  assign wrHit = t3 & chanToMem & anyValidMatch;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
      chanDone <= 1'b0;
      chanWrCache <= 1'b0;
      chanRdWait <= 1'b0;
    end else begin
      t1 <= chanGrant;
      t2 <= t1;
      t3 <= t2;
      chanDone <= (t3 & ~rdWaitStart) | (chanRdWait & cacheToMbDone);
      chanWrCache <= wrHit;
      chanRdWait <= rdWaitStart | (chanRdWait & ~cacheToMbDone);
    end
  end

  assign chanStatus = {1'b0, chanToMem, chanRdWait, chanWrCache, chanDone, t3, t2, t1};

endmodule

// ==== src/diagReadout.sv ====
`timescale 1ns/1ps

module diagReadout (
  input  logic                            diagEn,
  input  logic [cshPkg::diagSelWidth-1:0] diagSel,
  input  logic [cshPkg::diagWidth-1:0]    arbStatus,
  input  logic [cshPkg::diagWidth-1:0]    wayStatus,
  input  logic [cshPkg::diagWidth-1:0]    eboxStatus,
  input  logic [cshPkg::diagWidth-1:0]    chanStatus,
  output logic [cshPkg::diagWidth-1:0]    diagData
);

  always_comb begin
    diagData = '0;
    if (diagEn) begin
      case (diagSel)
        3'd0: diagData = arbStatus;
        3'd1: diagData = wayStatus;
        3'd2: diagData = eboxStatus;
        3'd3: diagData = chanStatus;
        // Upper selects unused
        default: diagData = '0;
      endcase
    end
  end

endmodule

// ==== src/cacheControl.sv ====
`timescale 1ns/1ps

module cacheControl (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            chanReq,
  input  logic                            eboxReq,
  input  logic                            vmaRead,
  input  logic                            cacheBit,
  input  logic                            chanToMem,
  input  logic [cshPkg::numWays-1:0]      validMatch,
  input  logic [cshPkg::numWays-1:0]      anyWr,
  input  logic [cshPkg::numWays-1:0]      wdVal,
  input  logic [cshPkg::lruWidth-1:0]     lru,
  input  logic                            eboxCycAbort,
  input  logic                            coreDataValid,
  input  logic                            cacheToMbDone,
  input  logic                            diagEn,
  input  logic [cshPkg::diagSelWidth-1:0] diagSel,
  output logic                            chanGrant,
  output logic                            eboxGrant,
  output logic                            readyToGo,
  output logic                            mboxResp,
  output logic                            coreRdRq,
  output logic                            cacheWr,
  output logic                            oneWordWr,
  output logic                            writeback,
  output logic                            eboxRetryReq,
  output logic                            chanWrCache,
  output logic                            chanRdWait,
  output logic [cshPkg::diagWidth-1:0]    diagData
);
  import cshPkg::*;

  logic eboxDone;
  logic chanDone;
  logic anyValidMatch;
  logic rdFound;
  logic anyWrittenMatch;
  logic lruAnyWr;
  logic [diagWidth-1:0] arbStatus;
  logic [diagWidth-1:0] wayStatus;
  logic [diagWidth-1:0] eboxStatus;
  logic [diagWidth-1:0] chanStatus;

  cycleArbiter uArb (
    .clk(clk), .rstN(rstN), .chanReq(chanReq), .eboxReq(eboxReq),
    .eboxDone(eboxDone), .chanDone(chanDone), .chanGrant(chanGrant),
    .eboxGrant(eboxGrant), .readyToGo(readyToGo), .arbStatus(arbStatus)
  );

  wayMatchSummary uWays (
    .validMatch(validMatch), .anyWr(anyWr), .wdVal(wdVal), .lru(lru),
    .anyValidMatch(anyValidMatch), .rdFound(rdFound),
    .anyWrittenMatch(anyWrittenMatch), .lruAnyWr(lruAnyWr), .wayStatus(wayStatus)
  );

  eboxSequencer uEbox (
    .clk(clk), .rstN(rstN), .eboxGrant(eboxGrant), .eboxCycAbort(eboxCycAbort),
    .vmaRead(vmaRead), .cacheBit(cacheBit), .coreDataValid(coreDataValid),
    .anyValidMatch(anyValidMatch), .rdFound(rdFound), .lruAnyWr(lruAnyWr),
    .eboxDone(eboxDone), .mboxResp(mboxResp), .coreRdRq(coreRdRq), .cacheWr(cacheWr),
    .oneWordWr(oneWordWr), .writeback(writeback), .eboxRetryReq(eboxRetryReq),
    .eboxStatus(eboxStatus)
  );

  chanSequencer uChan (
    .clk(clk), .rstN(rstN), .chanGrant(chanGrant), .chanToMem(chanToMem),
    .cacheToMbDone(cacheToMbDone), .anyValidMatch(anyValidMatch),
    .anyWrittenMatch(anyWrittenMatch), .chanDone(chanDone), .chanWrCache(chanWrCache),
    .chanRdWait(chanRdWait), .chanStatus(chanStatus)
  );

  diagReadout uDiag (
    .diagEn(diagEn), .diagSel(diagSel), .arbStatus(arbStatus), .wayStatus(wayStatus),
    .eboxStatus(eboxStatus), .chanStatus(chanStatus), .diagData(diagData)
  );

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rstN
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held for 10 cycles
  initial begin
    rstN <= 1'b0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// ==== tb/cacheControlTb.sv ====
`timescale 1ns/1ps

module cacheControlTb;
  import cshPkg::*;

  // Expected outcome of the running cycle
  localparam int kNone = 0;
  localparam int kReadHit = 1;
  localparam int kReadMiss = 2;
  localparam int kWriteHit = 3;
  localparam int kWriteUnc = 4;
  localparam int kWriteback = 5;
  localparam int kAbort = 6;
  localparam int kChanWrHit = 7;
  localparam int kChanRdWait = 8;
  localparam int waitLimit = 40;
  localparam int runLimit = 2000;

  logic clk;
  logic rstN;
  logic chanReq;
  logic eboxReq;
  logic vmaRead;
  logic cacheBit;
  logic chanToMem;
  logic [numWays-1:0] validMatch;
  logic [numWays-1:0] anyWr;
  logic [numWays-1:0] wdVal;
  logic [lruWidth-1:0] lru;
  logic eboxCycAbort;
  logic coreDataValid;
  logic cacheToMbDone;
  logic diagEn;
  logic [diagSelWidth-1:0] diagSel;
  logic chanGrant;
  logic eboxGrant;
  logic readyToGo;
  logic mboxResp;
  logic coreRdRq;
  logic cacheWr;
  logic oneWordWr;
  logic writeback;
  logic eboxRetryReq;
  logic chanWrCache;
  logic chanRdWait;
  logic [diagWidth-1:0] diagData;

  int expOut;
  int expChan;
  int errCount;
  int timeoutCount;
  integer seed;
  logic hung;
  logic runDone;

  clockGen uClk (.clk(clk), .rstN(rstN));

  cacheControl UUT (
    .clk(clk), .rstN(rstN), .chanReq(chanReq), .eboxReq(eboxReq), .vmaRead(vmaRead),
    .cacheBit(cacheBit), .chanToMem(chanToMem), .validMatch(validMatch), .anyWr(anyWr),
    .wdVal(wdVal), .lru(lru), .eboxCycAbort(eboxCycAbort), .coreDataValid(coreDataValid),
    .cacheToMbDone(cacheToMbDone), .diagEn(diagEn), .diagSel(diagSel),
    .chanGrant(chanGrant), .eboxGrant(eboxGrant), .readyToGo(readyToGo),
    .mboxResp(mboxResp), .coreRdRq(coreRdRq), .cacheWr(cacheWr), .oneWordWr(oneWordWr),
    .writeback(writeback), .eboxRetryReq(eboxRetryReq), .chanWrCache(chanWrCache),
    .chanRdWait(chanRdWait), .diagData(diagData)
  );

  task flagError(input string msg);
    errCount++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  function logic pick(input int which);
    case (which)
      0: pick = eboxGrant;
      1: pick = chanGrant;
      2: pick = readyToGo;
      3: pick = coreRdRq;
      4: pick = chanRdWait;
      default: pick = rstN;
    endcase
  endfunction

  // Polls at the falling edge where outputs are settled
  task waitFor(input int which, input string what);
    int count;
    count = 0;
    @(negedge clk);
    while (!pick(which) && count < waitLimit) begin
      @(negedge clk);
      count++;
    end
    if (!pick(which)) begin
      timeoutCount++;
      $display("TIMEOUT at %0t: %s did not arrive", $time, what);
      hung = 1'b1;
    end
  endtask

  task runEbox(input logic rd, input logic cb, input logic [3:0] vm, input logic [3:0] wr,
               input logic [3:0] wv, input logic [1:0] lruSel, input int kind);
    int delay;
    @(posedge clk);
    vmaRead <= rd;
    cacheBit <= cb;
    validMatch <= vm;
    anyWr <= wr;
    wdVal <= wv;
    lru <= lruSel;
    expOut <= kind;
    eboxReq <= 1'b1;
    waitFor(0, "eboxGrant");
    @(posedge clk);
    eboxReq <= 1'b0;
    // Abort lands in T1
    if (kind == kAbort) begin
      @(posedge clk);
      eboxCycAbort <= 1'b1;
      @(posedge clk);
      eboxCycAbort <= 1'b0;
    end
    if (kind == kReadMiss) begin
      waitFor(3, "coreRdRq");
      delay = $random(seed) & 7;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      coreDataValid <= 1'b1;
      @(posedge clk);
      coreDataValid <= 1'b0;
    end
    waitFor(2, "readyToGo after EBOX cycle");
  endtask

  task runChan(input logic toMem, input logic [3:0] vm, input logic [3:0] wr,
               input int kind, input logic alsoEbox);
    int delay;
    @(posedge clk);
    chanToMem <= toMem;
    validMatch <= vm;
    anyWr <= wr;
    expChan <= kind;
    chanReq <= 1'b1;
    eboxReq <= alsoEbox;
    waitFor(1, "chanGrant");
    @(posedge clk);
    chanReq <= 1'b0;
    if (kind == kChanRdWait) begin
      waitFor(4, "chanRdWait");
      delay = $random(seed) & 7;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      cacheToMbDone <= 1'b1;
      @(posedge clk);
      cacheToMbDone <= 1'b0;
    end
    // EBOX request left pending behind the channel
    if (alsoEbox) begin
      waitFor(0, "pending eboxGrant");
      @(posedge clk);
      eboxReq <= 1'b0;
    end
    waitFor(2, "readyToGo after channel cycle");
  endtask

  // Arbitration
  assert property (@(posedge clk) disable iff (!rstN)
    !(chanGrant && eboxGrant) && (!eboxGrant || (readyToGo && eboxReq && !chanReq)))
    else flagError("EBOX grant without a free cycle or over a channel request");
  assert property (@(posedge clk) disable iff (!rstN)
    (readyToGo && chanReq) |-> chanGrant)
    else flagError("channel request not granted in a ready cycle");
  assert property (@(posedge clk) disable iff (!rstN)
    (chanGrant |-> readyToGo) and ($past(chanGrant || eboxGrant) |-> !readyToGo))
    else flagError("grant outside a ready cycle or longer than one cycle");

  // Processor outcomes, four cycles after the grant
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && (expOut == kReadHit || expOut == kWriteHit || expOut == kWriteUnc))
    |-> mboxResp && !coreRdRq && !writeback)
    else flagError("mboxResp missing four cycles after grant");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kReadHit) |-> !cacheWr && !oneWordWr)
    else flagError("extra result pulse on read hit");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kWriteHit) |-> cacheWr && !oneWordWr)
    else flagError("write hit without cacheWr");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kWriteUnc) |-> oneWordWr && !cacheWr)
    else flagError("uncached write without oneWordWr");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kWriteback) |-> writeback && eboxRetryReq && !mboxResp)
    else flagError("dirty victim without writeback and retry");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kAbort)
    |-> !(mboxResp || cacheWr || oneWordWr || writeback || coreRdRq))
    else flagError("result given on aborted cycle");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 3) && expOut == kAbort) |-> readyToGo)
    else flagError("aborted cycle did not free the cache");
  assert property (@(posedge clk) disable iff (!rstN)
    mboxResp |-> $past(eboxGrant, 4) || $past(coreRdRq && coreDataValid))
    else flagError("unexpected mboxResp");
  assert property (@(posedge clk) disable iff (!rstN)
    $past(mboxResp || writeback) |-> readyToGo)
    else flagError("readyToGo not back one cycle after processor result");

  // Core read
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(eboxGrant, 4) && expOut == kReadMiss) |-> coreRdRq && !mboxResp)
    else flagError("read miss without coreRdRq");
  assert property (@(posedge clk) disable iff (!rstN)
    $past(coreRdRq && !coreDataValid) |-> coreRdRq)
    else flagError("coreRdRq dropped before coreDataValid");
  assert property (@(posedge clk) disable iff (!rstN)
    $past(coreRdRq && coreDataValid) |-> mboxResp && !coreRdRq)
    else flagError("no mboxResp after core data");

  // Channel cycles
  assert property (@(posedge clk) disable iff (!rstN)
    (($past(chanGrant, 4) && expChan == kChanWrHit) |-> chanWrCache) and
    (chanWrCache |-> $past(chanGrant, 4)))
    else flagError("chanWrCache not four cycles after grant");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(chanGrant, 4) && expChan == kChanRdWait) |-> chanRdWait)
    else flagError("chanRdWait missing on read of written line");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(chanRdWait && !cacheToMbDone) |-> chanRdWait) and
    ($past(chanRdWait && cacheToMbDone) |-> !chanRdWait))
    else flagError("chanRdWait not held until cacheToMbDone");
  assert property (@(posedge clk) disable iff (!rstN)
    ($past(chanWrCache) || $past(chanRdWait && cacheToMbDone, 2)) |-> readyToGo)
    else flagError("readyToGo not back after channel cycle");

  // Diagnostic readout
  assert property (@(posedge clk) disable iff (!rstN)
    (!diagEn || diagSel[2]) |-> diagData == 8'h00)
    else flagError("diagData not zero");
  assert property (@(posedge clk) disable iff (!rstN)
    (diagEn && diagSel == 3'd1) |-> diagData == {anyWr, validMatch})
    else flagError("way status readout wrong");
  assert property (@(posedge clk) disable iff (!rstN)
    (diagEn && diagSel == 3'd0 && $past(chanGrant)) |-> diagData[1:0] == 2'b01)
    else flagError("channel cycle bit not shown");

  initial begin
    chanReq <= 1'b0;
    eboxReq <= 1'b0;
    vmaRead <= 1'b0;
    cacheBit <= 1'b0;
    chanToMem <= 1'b0;
    validMatch <= '0;
    anyWr <= '0;
    wdVal <= '0;
    lru <= '0;
    eboxCycAbort <= 1'b0;
    coreDataValid <= 1'b0;
    cacheToMbDone <= 1'b0;
    diagEn <= 1'b0;
    diagSel <= '0;
    expOut <= kNone;
    expChan <= kNone;
    errCount = 0;
    timeoutCount = 0;
    seed = 35405;
    hung = 1'b0;
    runDone = 1'b0;

    waitFor(5, "reset release");
    assert (readyToGo && !chanGrant && !eboxGrant && !mboxResp && !coreRdRq && !chanRdWait)
      else flagError("outputs not idle after reset");
    assert (diagData == 8'h00)
      else flagError("diagData not zero after reset");

    runEbox(1'b1, 1'b0, 4'b0100, 4'b0000, 4'b0100, 2'd0, kReadHit);
    runEbox(1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000, 2'd1, kReadMiss);
    runEbox(1'b1, 1'b1, 4'b0010, 4'b0000, 4'b0000, 2'd3, kReadMiss);
    runEbox(1'b0, 1'b1, 4'b1000, 4'b0000, 4'b0000, 2'd0, kWriteHit);
    runEbox(1'b0, 1'b0, 4'b0000, 4'b0000, 4'b0000, 2'd2, kWriteUnc);
    runEbox(1'b0, 1'b1, 4'b0000, 4'b0100, 4'b0000, 2'd2, kWriteback);
    runEbox(1'b1, 1'b0, 4'b0001, 4'b0000, 4'b0001, 2'd0, kAbort);

    @(posedge clk);
    diagEn <= 1'b1;
    diagSel <= 3'd1;
    validMatch <= 4'b1010;
    anyWr <= 4'b0110;
    @(posedge clk);
    diagSel <= 3'd0;
    vmaRead <= 1'b1;
    cacheBit <= 1'b0;
    wdVal <= 4'b0010;
    expOut <= kReadHit;
    runChan(1'b1, 4'b0010, 4'b0000, kChanWrHit, 1'b1);
    runChan(1'b0, 4'b0001, 4'b0001, kChanRdWait, 1'b0);

    for (int s = 4; s < 8; s++) begin
      @(posedge clk);
      diagSel <= s[2:0];
    end
    @(posedge clk);
    diagEn <= 1'b0;
    @(posedge clk);
    runDone = 1'b1;
  end

  // Closing report and bound on the whole run
  initial begin
    int cycles;
    cycles = 0;
    while (!runDone && !hung && cycles < runLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!runDone && !hung) begin
      timeoutCount++;
      $display("TIMEOUT at %0t: test sequence did not finish", $time);
    end
    $display("Errors: %0d failed checks, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/cshPkg.sv
src/cycleArbiter.sv
src/wayMatchSummary.sv
src/eboxSequencer.sv
src/chanSequencer.sv
src/diagReadout.sv
src/cacheControl.sv
tb/clockGen.sv
tb/cacheControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cacheControlTb -f vlog.f -o simCache
./obj_dir/simCache | tee sim.log

if grep -q "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
